/* source/xaui_pkg.sv */
`default_nettype none

package xaui_pkg;

  // ##############################
  // xgmii control codes
  // ##############################

  localparam logic [7:0] XGMII_IDLE  = 8'h07;
  localparam logic [7:0] XGMII_START = 8'hfb;
  localparam logic [7:0] XGMII_TERM  = 8'hfd;
  // fills bytes 1 to 7 of a start column.
  localparam logic [7:0] START_FILL  = 8'h55;

  // whole columns built from the codes above.
  localparam logic [63:0] IDLE_COL_DATA  = {8{XGMII_IDLE}};
  localparam logic [63:0] START_COL_DATA = {{7{START_FILL}}, XGMII_START};
  localparam logic [63:0] TERM_COL_DATA  = {{7{XGMII_IDLE}}, XGMII_TERM};
  localparam logic [7:0]  CHARISK_ALL    = 8'hff;
  localparam logic [7:0]  CHARISK_LANE0  = 8'h01;

  // ##############################
  // sizes and timing
  // ##############################

  localparam int FIFO_DEPTH         = 16;
  localparam int FIFO_AW            = $clog2(FIFO_DEPTH);
  localparam int MAX_BURST          = 8;
  localparam int BURST_W            = $clog2(MAX_BURST);
  localparam int LINK_UP_CYCLES     = 4;
  localparam int LINK_CNT_W         = $clog2(LINK_UP_CYCLES + 1);
  localparam int LED_STRETCH_CYCLES = 16;
  localparam int LED_CNT_W          = $clog2(LED_STRETCH_CYCLES + 1);

  // control bits after reset.
  localparam logic DEFAULT_TXEN      = 1'b1;
  localparam logic DEFAULT_LOOPBACK  = 1'b0;
  localparam logic DEFAULT_POWERDOWN = 1'b0;

  // register bus addresses.
  typedef enum logic [3:0] {
    REG_CTRL = 4'h0, REG_STATUS = 4'h1,
    REG_TX0 = 4'h4, REG_TX1 = 4'h5, REG_TX2 = 4'h6, REG_TX3 = 4'h7,
    REG_RX0 = 4'h8, REG_RX1 = 4'h9, REG_RX2 = 4'ha, REG_RX3 = 4'hb
  } reg_addr_e;

endpackage

`default_nettype wire

/* source/xaui_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module xaui_fifo
  import xaui_pkg::*;
(
  input  wire         mgt_clk,
  input  wire         reset_i,
  input  wire         wr_en_i,
  input  wire  [63:0] wr_data_i,
  input  wire         rd_en_i,
  output logic [63:0] rd_data_o,
  output logic        empty_o,
  output logic        full_o,
  output logic        overflow_o
);

  logic [63:0]        mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               push;
  logic               pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

  // writes while full and reads while empty are dropped.
  assign push = wr_en_i & ~full_o;
  assign pop  = rd_en_i & ~empty_o;

  // show-ahead, head word always visible.
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge mgt_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (reset_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy only moves when one side acts alone.
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // sticky until the next reset.
      if (wr_en_i && full_o) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/xaui_lane_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module xaui_lane_sync
  import xaui_pkg::*;
(
  input  wire        mgt_clk,
  input  wire        reset_i,
  input  wire  [3:0] syncok_i,
  output logic       link_up_o,
  output logic       link_down_strb_o
);

  typedef enum logic [1:0] {
    LINK_DOWN,
    LINK_QUAL,
    LINK_UP
  } link_state_e;

  link_state_e           state;
  logic [LINK_CNT_W-1:0] qual_cnt;
  logic                  all_sync;

  // every lane has to report sync.
  assign all_sync = &syncok_i;

  assign link_up_o = (state == LINK_UP);

  // ##############################
  // qualification FSM
  // ##############################

  always_ff @(posedge mgt_clk) begin
    if (reset_i) begin
      state    <= LINK_DOWN;
      qual_cnt <= '0;
    end else begin
      case (state)
        LINK_DOWN: begin
          if (all_sync) begin
            // first clean cycle already counts.
            qual_cnt <= LINK_CNT_W'(1);
            state    <= LINK_QUAL;
          end
        end
        LINK_QUAL: begin
          if (!all_sync) begin
            state <= LINK_DOWN;
          end else if (qual_cnt == LINK_CNT_W'(LINK_UP_CYCLES - 1)) begin
            state <= LINK_UP;
          end else begin
            qual_cnt <= qual_cnt + 1'b1;
          end
        end
        LINK_UP: begin
          if (!all_sync) begin
            state <= LINK_DOWN;
          end
        end
        default: begin
          state <= LINK_DOWN;
        end
      endcase
    end
  end

  // one pulse in the cycle the link drops.
  always_ff @(posedge mgt_clk) begin
    if (reset_i) begin
      link_down_strb_o <= 1'b0;
    end else begin
      link_down_strb_o <= (state == LINK_UP) & ~all_sync;
    end
  end

endmodule

`default_nettype wire

/* source/xaui_transfer_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module xaui_transfer_engine
  import xaui_pkg::*;
(
  input  wire         mgt_clk,
  input  wire         reset_i,
  input  wire         txen_i,
  input  wire         link_up_i,
  input  wire  [63:0] tx_data_i,
  input  wire         tx_empty_i,
  output logic        tx_rd_en_o,
  output logic [63:0] mgt_txdata_o,
  output logic [7:0]  mgt_txcharisk_o,
  input  wire  [63:0] mgt_rxdata_i,
  input  wire  [7:0]  mgt_rxcharisk_i,
  output logic        rx_wr_en_o,
  output logic [63:0] rx_wr_data_o,
  output logic        tx_strb_o,
  output logic        rx_strb_o
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_TERM
  } tx_state_e;

  tx_state_e          tx_state;
  logic [BURST_W-1:0] burst_cnt;
  logic               tx_go;
  logic               rx_is_start;
  logic               rx_is_term;
  logic               rx_is_data;
  logic               rx_in_frame;

  // ##############################
  // transmit framer
  // ##############################

  assign tx_go = txen_i & link_up_i & ~tx_empty_i;

  // head word leaves the FIFO as its data column is registered.
  assign tx_rd_en_o = (tx_state == TX_DATA) & ~tx_empty_i;

  always_ff @(posedge mgt_clk) begin
    if (reset_i) begin
      tx_state        <= TX_IDLE;
      burst_cnt       <= '0;
      mgt_txdata_o    <= IDLE_COL_DATA;
      mgt_txcharisk_o <= CHARISK_ALL;
      tx_strb_o       <= 1'b0;
    end else begin
      tx_strb_o <= 1'b0;
      case (tx_state)
        TX_IDLE: begin
          // one idle column always sits between frames.
          mgt_txdata_o    <= IDLE_COL_DATA;
          mgt_txcharisk_o <= CHARISK_ALL;
          if (tx_go) begin
            tx_state <= TX_START;
          end
        end
        TX_START: begin
          mgt_txdata_o    <= START_COL_DATA;
          mgt_txcharisk_o <= CHARISK_LANE0;
          burst_cnt       <= '0;
          tx_state        <= TX_DATA;
        end
        TX_DATA: begin
          if (tx_empty_i) begin
            // ran dry, close the frame early.
            mgt_txdata_o    <= TERM_COL_DATA;
            mgt_txcharisk_o <= CHARISK_ALL;
            tx_strb_o       <= 1'b1;
            tx_state        <= TX_IDLE;
          end else begin
            mgt_txdata_o    <= tx_data_i;
            mgt_txcharisk_o <= 8'h00;
            burst_cnt       <= burst_cnt + 1'b1;
            if (burst_cnt == BURST_W'(MAX_BURST - 1)) begin
              tx_state <= TX_TERM;
            end
          end
        end
        TX_TERM: begin
          mgt_txdata_o    <= TERM_COL_DATA;
          mgt_txcharisk_o <= CHARISK_ALL;
          tx_strb_o       <= 1'b1;
          tx_state        <= TX_IDLE;
        end
        default: begin
          tx_state <= TX_IDLE;
        end
      endcase
    end
  end

  // ##############################
  // receive deframer
  // ##############################

  assign rx_is_start = mgt_rxcharisk_i[0] & (mgt_rxdata_i[7:0] == XGMII_START);
  assign rx_is_term  = mgt_rxcharisk_i[0] & (mgt_rxdata_i[7:0] == XGMII_TERM);
  assign rx_is_data  = (mgt_rxcharisk_i == 8'h00);

  always_ff @(posedge mgt_clk) begin
    if (reset_i) begin
      rx_in_frame <= 1'b0;
      rx_wr_en_o  <= 1'b0;
      rx_strb_o   <= 1'b0;
    end else begin
      rx_wr_en_o <= link_up_i & rx_in_frame & rx_is_data;
      rx_strb_o  <= link_up_i & rx_in_frame & rx_is_term;
      // a lost link abandons any open frame.
      if (!link_up_i) begin
        rx_in_frame <= 1'b0;
      end else if (rx_is_start) begin
        rx_in_frame <= 1'b1;
      end else if (rx_is_term) begin
        rx_in_frame <= 1'b0;
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    rx_wr_data_o <= mgt_rxdata_i;
  end

endmodule

`default_nettype wire

/* source/xaui_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module xaui_pipe_ctrl
  import xaui_pkg::*;
(
  input  wire         mgt_clk,
  input  wire         reset,
  input  wire         reg_stb_i,
  input  wire         reg_we_i,
  input  wire  [3:0]  reg_adr_i,
  input  wire  [15:0] reg_dat_i,
  output logic [15:0] reg_dat_o,
  output logic        reg_ack_o,
  output logic        tx_wr_en_o,
  output logic [63:0] tx_wr_data_o,
  output logic        rx_rd_en_o,
  input  wire  [63:0] rx_data_i,
  input  wire         tx_empty_i,
  input  wire         tx_full_i,
  input  wire         tx_overflow_i,
  input  wire         rx_empty_i,
  input  wire         rx_full_i,
  input  wire         rx_overflow_i,
  input  wire         link_up_i,
  input  wire         rx_strb_i,
  input  wire         tx_strb_i,
  input  wire         link_down_strb_i,
  output logic        txen_o,
  output logic        mgt_loopback_o,
  output logic        mgt_powerdown_o,
  output logic        dp_reset_o,
  output logic [2:0]  leds_o
);

  reg_addr_e   bus_addr;
  logic        bus_write;
  logic        bus_read;
  logic        ctrl_write;
  logic [47:0] tx_stage;
  logic [1:0]  soft_cnt;
  logic [2:0]  led_strb;

  // ##############################
  // register bus
  // ##############################

  assign bus_addr = reg_addr_e'(reg_adr_i);

  // one ack per strobe, in the cycle after it is seen.
  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      reg_ack_o <= 1'b0;
    end else begin
      reg_ack_o <= reg_stb_i & ~reg_ack_o;
    end
  end

  // accesses take effect in the ack cycle.
  assign bus_write  = reg_stb_i & reg_ack_o & reg_we_i;
  assign bus_read   = reg_stb_i & reg_ack_o & ~reg_we_i;
  assign ctrl_write = bus_write & (bus_addr == REG_CTRL);

  assign tx_wr_en_o   = bus_write & (bus_addr == REG_TX3);
  assign tx_wr_data_o = {reg_dat_i, tx_stage};
  assign rx_rd_en_o   = bus_read & (bus_addr == REG_RX3);

  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      txen_o          <= DEFAULT_TXEN;
      mgt_loopback_o  <= DEFAULT_LOOPBACK;
      mgt_powerdown_o <= DEFAULT_POWERDOWN;
    end else if (ctrl_write) begin
      txen_o          <= reg_dat_i[0];
      mgt_loopback_o  <= reg_dat_i[1];
      mgt_powerdown_o <= reg_dat_i[2];
    end
  end

  // lower three quarters of the next tx word.
  always_ff @(posedge mgt_clk) begin
    if (bus_write && bus_addr == REG_TX0) begin
      tx_stage[15:0] <= reg_dat_i;
    end
    if (bus_write && bus_addr == REG_TX1) begin
      tx_stage[31:16] <= reg_dat_i;
    end
    if (bus_write && bus_addr == REG_TX2) begin
      tx_stage[47:32] <= reg_dat_i;
    end
  end

  always_comb begin
    case (bus_addr)
      REG_CTRL:   reg_dat_o = {13'd0, mgt_powerdown_o, mgt_loopback_o, txen_o};
      REG_STATUS: reg_dat_o = {9'd0, rx_overflow_i, tx_overflow_i, rx_full_i,
                               rx_empty_i, tx_full_i, tx_empty_i, link_up_i};
      REG_TX0:    reg_dat_o = tx_stage[15:0];
      REG_TX1:    reg_dat_o = tx_stage[31:16];
      REG_TX2:    reg_dat_o = tx_stage[47:32];
      REG_RX0:    reg_dat_o = rx_data_i[15:0];
      REG_RX1:    reg_dat_o = rx_data_i[31:16];
      REG_RX2:    reg_dat_o = rx_data_i[47:32];
      REG_RX3:    reg_dat_o = rx_data_i[63:48];
      default:    reg_dat_o = 16'd0;
    endcase
  end

  // ##############################
  // soft reset and leds
  // ##############################

  // two cycle datapath reset, control bits survive it.
  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      soft_cnt <= 2'd0;
    end else if (ctrl_write && reg_dat_i[3]) begin
      soft_cnt <= 2'd2;
    end else if (soft_cnt != 2'd0) begin
      soft_cnt <= soft_cnt - 1'b1;
    end
  end

  assign dp_reset_o = reset | (soft_cnt != 2'd0);

  assign led_strb = {rx_strb_i, tx_strb_i, link_down_strb_i};

  for (genvar i = 0; i < 3; i++) begin : g_led
    logic [LED_CNT_W-1:0] stretch_cnt;

    // strobes arriving while lit are absorbed.
    always_ff @(posedge mgt_clk) begin
      if (dp_reset_o) begin
        stretch_cnt <= '0;
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end else if (led_strb[i]) begin
        stretch_cnt <= LED_CNT_W'(LED_STRETCH_CYCLES);
      end
    end

    assign leds_o[i] = (stretch_cnt != '0);
  end

endmodule

`default_nettype wire

/* source/xaui_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module xaui_pipe (
  input  wire         mgt_clk,
  input  wire         reset,
  input  wire         reg_stb_i,
  input  wire         reg_we_i,
  input  wire  [3:0]  reg_adr_i,
  input  wire  [15:0] reg_dat_i,
  output wire  [15:0] reg_dat_o,
  output wire         reg_ack_o,
  output wire  [63:0] mgt_txdata_o,
  output wire  [7:0]  mgt_txcharisk_o,
  input  wire  [63:0] mgt_rxdata_i,
  input  wire  [7:0]  mgt_rxcharisk_i,
  input  wire  [3:0]  mgt_syncok_i,
  output wire         mgt_loopback_o,
  output wire         mgt_powerdown_o,
  output wire  [2:0]  leds_o
);

  // fifo side.
  wire        tx_wr_en;
  wire [63:0] tx_wr_data;
  wire        tx_rd_en;
  wire [63:0] tx_rd_data;
  wire        tx_empty;
  wire        tx_full;
  wire        tx_overflow;
  wire        rx_wr_en;
  wire [63:0] rx_wr_data;
  wire        rx_rd_en;
  wire [63:0] rx_rd_data;
  wire        rx_empty;
  wire        rx_full;
  wire        rx_overflow;

  // link and engine status.
  wire        link_up;
  wire        link_down_strb;
  wire        tx_strb;
  wire        rx_strb;
  wire        txen;
  wire        dp_reset;

  xaui_pipe_ctrl i_ctrl (
    .mgt_clk          (mgt_clk),
    .reset            (reset),
    .reg_stb_i        (reg_stb_i),
    .reg_we_i         (reg_we_i),
    .reg_adr_i        (reg_adr_i),
    .reg_dat_i        (reg_dat_i),
    .reg_dat_o        (reg_dat_o),
    .reg_ack_o        (reg_ack_o),
    .tx_wr_en_o       (tx_wr_en),
    .tx_wr_data_o     (tx_wr_data),
    .rx_rd_en_o       (rx_rd_en),
    .rx_data_i        (rx_rd_data),
    .tx_empty_i       (tx_empty),
    .tx_full_i        (tx_full),
    .tx_overflow_i    (tx_overflow),
    .rx_empty_i       (rx_empty),
    .rx_full_i        (rx_full),
    .rx_overflow_i    (rx_overflow),
    .link_up_i        (link_up),
    .rx_strb_i        (rx_strb),
    .tx_strb_i        (tx_strb),
    .link_down_strb_i (link_down_strb),
    .txen_o           (txen),
    .mgt_loopback_o   (mgt_loopback_o),
    .mgt_powerdown_o  (mgt_powerdown_o),
    .dp_reset_o       (dp_reset),
    .leds_o           (leds_o)
  );

  xaui_fifo i_tx_fifo (
    .mgt_clk    (mgt_clk),
    .reset_i    (dp_reset),
    .wr_en_i    (tx_wr_en),
    .wr_data_i  (tx_wr_data),
    .rd_en_i    (tx_rd_en),
    .rd_data_o  (tx_rd_data),
    .empty_o    (tx_empty),
    .full_o     (tx_full),
    .overflow_o (tx_overflow)
  );

  xaui_fifo i_rx_fifo (
    .mgt_clk    (mgt_clk),
    .reset_i    (dp_reset),
    .wr_en_i    (rx_wr_en),
    .wr_data_i  (rx_wr_data),
    .rd_en_i    (rx_rd_en),
    .rd_data_o  (rx_rd_data),
    .empty_o    (rx_empty),
    .full_o     (rx_full),
    .overflow_o (rx_overflow)
  );

  xaui_lane_sync i_lane_sync (
    .mgt_clk          (mgt_clk),
    .reset_i          (dp_reset),
    .syncok_i         (mgt_syncok_i),
    .link_up_o        (link_up),
    .link_down_strb_o (link_down_strb)
  );

  xaui_transfer_engine i_engine (
    .mgt_clk         (mgt_clk),
    .reset_i         (dp_reset),
    .txen_i          (txen),
    .link_up_i       (link_up),
    .tx_data_i       (tx_rd_data),
    .tx_empty_i      (tx_empty),
    .tx_rd_en_o      (tx_rd_en),
    .mgt_txdata_o    (mgt_txdata_o),
    .mgt_txcharisk_o (mgt_txcharisk_o),
    .mgt_rxdata_i    (mgt_rxdata_i),
    .mgt_rxcharisk_i (mgt_rxcharisk_i),
    .rx_wr_en_o      (rx_wr_en),
    .rx_wr_data_o    (rx_wr_data),
    .tx_strb_o       (tx_strb),
    .rx_strb_o       (rx_strb)
  );

endmodule

`default_nettype wire

/* verif/xaui_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xaui_pipe_tb
  import xaui_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;

  // reference columns built from the xgmii codes.
  localparam logic [63:0] COL_IDLE  = {8{XGMII_IDLE}};
  localparam logic [63:0] COL_START = {{7{START_FILL}}, XGMII_START};
  localparam logic [63:0] COL_TERM  = {{7{XGMII_IDLE}}, XGMII_TERM};

  logic        mgt_clk = 1'b0;
  logic        reset;
  logic        reg_stb_i;
  logic        reg_we_i;
  logic [3:0]  reg_adr_i;
  logic [15:0] reg_dat_i;
  wire  [15:0] reg_dat_o;
  wire         reg_ack_o;
  wire  [63:0] mgt_txdata_o;
  wire  [7:0]  mgt_txcharisk_o;
  wire  [63:0] mgt_rxdata_i;
  wire  [7:0]  mgt_rxcharisk_i;
  logic [3:0]  mgt_syncok_i;
  wire         mgt_loopback_o;
  wire         mgt_powerdown_o;
  wire  [2:0]  leds_o;

  // external loopback path and direct rx drive.
  logic        loop_en;
  logic [63:0] loop_data;
  logic [7:0]  loop_k;
  logic [63:0] rx_drv_data;
  logic [7:0]  rx_drv_k;

  // bookkeeping.
  int          seed = 38;
  string       cur_test = "setup";
  int          err_count = 0;
  int          mon_err = 0;
  int          test_err_base = 0;
  int          n_tests = 0;
  int          n_failed = 0;
  int          cycle_cnt;
  logic [63:0] sb_q[$];

  // tx monitor state.
  logic        mon_in_frame = 1'b0;
  logic        mon_after_term = 1'b0;
  int          mon_burst = 0;
  int          mon_data_total = 0;
  int          mon_bursts[$];
  int          ld_led_cycles = 0;
  int          tx_led_cycles = 0;
  int          rx_led_cycles = 0;

  wire tx_is_idle  = (mgt_txcharisk_o == 8'hff) && (mgt_txdata_o == COL_IDLE);
  wire tx_is_start = (mgt_txcharisk_o == 8'h01) && (mgt_txdata_o == COL_START);
  wire tx_is_term  = (mgt_txcharisk_o == 8'hff) && (mgt_txdata_o == COL_TERM);
  wire tx_is_data  = (mgt_txcharisk_o == 8'h00);

  always #4 mgt_clk = ~mgt_clk;

  xaui_pipe i_dut (
    .mgt_clk         (mgt_clk),
    .reset           (reset),
    .reg_stb_i       (reg_stb_i),
    .reg_we_i        (reg_we_i),
    .reg_adr_i       (reg_adr_i),
    .reg_dat_i       (reg_dat_i),
    .reg_dat_o       (reg_dat_o),
    .reg_ack_o       (reg_ack_o),
    .mgt_txdata_o    (mgt_txdata_o),
    .mgt_txcharisk_o (mgt_txcharisk_o),
    .mgt_rxdata_i    (mgt_rxdata_i),
    .mgt_rxcharisk_i (mgt_rxcharisk_i),
    .mgt_syncok_i    (mgt_syncok_i),
    .mgt_loopback_o  (mgt_loopback_o),
    .mgt_powerdown_o (mgt_powerdown_o),
    .leds_o          (leds_o)
  );

  // tx pins come back one cycle later.
  always @(posedge mgt_clk) begin
    loop_data <= mgt_txdata_o;
    loop_k    <= mgt_txcharisk_o;
  end

  assign mgt_rxdata_i    = loop_en ? loop_data : rx_drv_data;
  assign mgt_rxcharisk_i = loop_en ? loop_k : rx_drv_k;

  // ##############################
  // tx monitor
  // ##############################

  function automatic void report_column_error(input string msg);
    $display("%s: %s", cur_test, msg);
    mon_err++;
  endfunction

  always @(negedge mgt_clk) begin
    if (reset) begin
      mon_in_frame   <= 1'b0;
      mon_after_term <= 1'b0;
      mon_burst      <= 0;
    end else begin
      assert (tx_is_idle || tx_is_start || tx_is_term || tx_is_data)
        else report_column_error("tx pins carry a column of unknown kind");
      if (tx_is_data) begin
        assert (mon_in_frame) else report_column_error("data column sent outside a frame");
        assert (mon_burst < MAX_BURST) else report_column_error("frame exceeds the burst limit");
        mon_burst      <= mon_burst + 1;
        mon_data_total <= mon_data_total + 1;
        mon_after_term <= 1'b0;
      end else if (tx_is_start) begin
        assert (!mon_in_frame && !mon_after_term)
          else report_column_error("start column without an idle column before it");
        mon_in_frame   <= 1'b1;
        mon_burst      <= 0;
        mon_after_term <= 1'b0;
      end else if (tx_is_term) begin
        assert (mon_in_frame && mon_burst > 0)
          else report_column_error("terminate column without framed data");
        mon_bursts.push_back(mon_burst);
        mon_in_frame   <= 1'b0;
        mon_after_term <= 1'b1;
      end else if (tx_is_idle) begin
        assert (!mon_in_frame) else report_column_error("idle column inside a frame");
        mon_after_term <= 1'b0;
      end
    end
    if (leds_o[0]) ld_led_cycles <= ld_led_cycles + 1;
    if (leds_o[1]) tx_led_cycles <= tx_led_cycles + 1;
    if (leds_o[2]) rx_led_cycles <= rx_led_cycles + 1;
  end

  // ##############################
  // checks and bus tasks
  // ##############################

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic confirm(input logic cond, input string msg);
    assert (cond) else begin
      $display("%s: %s", cur_test, msg);
      err_count++;
    end
  endtask

  task automatic open_test(input string name);
    cur_test      = name;
    test_err_base = err_count + mon_err;
  endtask

  task automatic close_test();
    int errs;
    errs = err_count + mon_err - test_err_base;
    n_tests++;
    if (errs == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      n_failed++;
      $display("%s: FAIL, %0d errors", cur_test, errs);
    end
  endtask

  function automatic logic [15:0] status_word(input logic link, input logic txe,
                                              input logic txf, input logic rxe,
                                              input logic rxf, input logic txo,
                                              input logic rxo);
    return {9'd0, rxo, txo, rxf, rxe, txf, txe, link};
  endfunction

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // strobe held until ack and dropped on the edge that ends the ack cycle.
  task automatic bus_access(input logic we, input reg_addr_e adr, input logic [15:0] wdat,
                            output logic [15:0] rdat);
    int n;
    @(posedge mgt_clk);
    reg_stb_i <= 1'b1;
    reg_we_i  <= we;
    reg_adr_i <= adr;
    reg_dat_i <= wdat;
    n = 0;
    while (reg_ack_o !== 1'b1 && n < 8) begin
      @(negedge mgt_clk);
      n++;
    end
    confirm(reg_ack_o === 1'b1, "register bus never acknowledged the strobe");
    check_value("ack latency in cycles", 64'd2, 64'(n));
    rdat = reg_dat_o;
    @(posedge mgt_clk);
    reg_stb_i <= 1'b0;
    reg_we_i  <= 1'b0;
  endtask

  task automatic bus_write(input reg_addr_e adr, input logic [15:0] wdat);
    logic [15:0] unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic bus_read(input reg_addr_e adr, output logic [15:0] rdat);
    bus_access(1'b0, adr, 16'd0, rdat);
  endtask

  task automatic write_tx_word(input logic [63:0] w);
    bus_write(REG_TX0, w[15:0]);
    bus_write(REG_TX1, w[31:16]);
    bus_write(REG_TX2, w[47:32]);
    bus_write(REG_TX3, w[63:48]);
  endtask

  // rx3 goes last since it pops the head.
  task automatic check_rx_word(input logic [63:0] exp);
    logic [63:0] q;
    bus_read(REG_RX0, q[15:0]);
    bus_read(REG_RX1, q[31:16]);
    bus_read(REG_RX2, q[47:32]);
    bus_read(REG_RX3, q[63:48]);
    check_value("rx word", exp, q);
  endtask

  task automatic wait_link(input logic want_up);
    logic [15:0] st;
    int n;
    n = 0;
    bus_read(REG_STATUS, st);
    while (st[0] !== want_up && n < 20) begin
      bus_read(REG_STATUS, st);
      n++;
    end
    confirm(st[0] === want_up, "link state did not change within the poll limit");
  endtask

  task automatic set_loopback(input logic en);
    logic [15:0] c;
    bus_read(REG_CTRL, c);
    c[1] = en;
    bus_write(REG_CTRL, c);
    @(negedge mgt_clk);
    check_value("loopback pin", 64'(en), 64'(mgt_loopback_o));
    @(posedge mgt_clk);
    loop_en <= en;
  endtask

  task automatic drive_column(input logic [63:0] data, input logic [7:0] k);
    @(posedge mgt_clk);
    rx_drv_data <= data;
    rx_drv_k    <= k;
  endtask

  task automatic drive_frame(input logic [63:0] w0, input logic [63:0] w1);
    drive_column(COL_START, 8'h01);
    drive_column(w0, 8'h00);
    drive_column(w1, 8'h00);
    drive_column(COL_TERM, 8'hff);
    drive_column(COL_IDLE, 8'hff);
    // one cycle to decode, one to land in the fifo.
    repeat (2) @(posedge mgt_clk);
  endtask

  task automatic wait_tx_drain(input int target);
    int n;
    n = 0;
    while ((mon_data_total < target || mon_in_frame) && n < 500) begin
      @(negedge mgt_clk);
      n++;
    end
    confirm(n < 500, "transmit frames did not finish in time");
    // loopback register plus rx write.
    repeat (3) @(posedge mgt_clk);
  endtask

  // ##############################
  // tests
  // ##############################

  task automatic reset_defaults();
    logic [15:0] q;
    open_test("reset_defaults");
    bus_read(REG_CTRL, q);
    check_value("ctrl", 64'h1, 64'(q));
    bus_read(REG_STATUS, q);
    check_value("status", 64'(status_word(0, 1, 0, 1, 0, 0, 0)), 64'(q));
    @(negedge mgt_clk);
    check_value("leds", 64'd0, 64'(leds_o));
    check_value("loopback pin", 64'd0, 64'(mgt_loopback_o));
    check_value("powerdown pin", 64'd0, 64'(mgt_powerdown_o));
    check_value("tx data", COL_IDLE, mgt_txdata_o);
    check_value("tx charisk", 64'hff, 64'(mgt_txcharisk_o));
    close_test();
  endtask

  task automatic qualify_link();
    logic [15:0] st;
    int n;
    int led_base;
    open_test("link_qualification");
    led_base = ld_led_cycles;
    @(posedge mgt_clk);
    mgt_syncok_i <= 4'hf;
    wait_link(1'b1);
    @(posedge mgt_clk);
    mgt_syncok_i <= 4'b1011;
    bus_read(REG_STATUS, st);
    check_value("link_up after lane loss", 64'd0, 64'(st[0]));
    n = 0;
    while (!leds_o[0] && n < 8) begin
      @(negedge mgt_clk);
      n++;
    end
    confirm(leds_o[0], "link-down LED never lit");
    n = 0;
    while (leds_o[0] && n < LED_STRETCH_CYCLES + 4) begin
      @(negedge mgt_clk);
      n++;
    end
    confirm(!leds_o[0], "link-down LED stayed lit past its stretch time");
    check_value("link-down LED lit cycles", 64'(LED_STRETCH_CYCLES),
                64'(ld_led_cycles - led_base));
    @(posedge mgt_clk);
    mgt_syncok_i <= 4'hf;
    wait_link(1'b1);
    close_test();
  endtask

  task automatic loopback_transfer();
    logic [15:0] st;
    logic [63:0] w;
    int data_base;
    int tx_led_base;
    int rx_led_base;
    open_test("loopback_transfer");
    tx_led_base = tx_led_cycles;
    rx_led_base = rx_led_cycles;
    set_loopback(1'b1);
    data_base = mon_data_total;
    for (int i = 0; i < 5; i++) begin
      w = rand_word();
      sb_q.push_back(w);
      write_tx_word(w);
    end
    wait_tx_drain(data_base + 5);
    for (int i = 0; i < 5; i++) begin
      check_rx_word(sb_q.pop_front());
    end
    bus_read(REG_STATUS, st);
    check_value("rx_empty", 64'd1, 64'(st[3]));
    confirm(tx_led_cycles > tx_led_base, "tx LED never lit");
    confirm(rx_led_cycles > rx_led_base, "rx LED never lit");
    close_test();
  endtask

  task automatic framing_rules();
    logic [63:0] w;
    int data_base;
    int frame_base;
    open_test("framing_rules");
    // queue the whole batch first so the burst limit splits it.
    bus_write(REG_CTRL, 16'h0002);
    for (int i = 0; i < 12; i++) begin
      w = rand_word();
      sb_q.push_back(w);
      write_tx_word(w);
    end
    data_base  = mon_data_total;
    frame_base = mon_bursts.size();
    bus_write(REG_CTRL, 16'h0003);
    wait_tx_drain(data_base + 12);
    check_value("frame count", 64'd2, 64'(mon_bursts.size() - frame_base));
    if (mon_bursts.size() >= frame_base + 2) begin
      check_value("first burst", 64'(MAX_BURST), 64'(mon_bursts[frame_base]));
      check_value("second burst", 64'(12 - MAX_BURST), 64'(mon_bursts[frame_base + 1]));
    end
    for (int i = 0; i < 12; i++) begin
      check_rx_word(sb_q.pop_front());
    end
    close_test();
  endtask

  task automatic receive_filtering();
    logic [15:0] st;
    logic [63:0] w0;
    logic [63:0] w1;
    int frame_base;
    int data_base;
    open_test("receive_filtering");
    set_loopback(1'b0);
    // stray data columns with no start.
    for (int i = 0; i < 3; i++) begin
      drive_column(rand_word(), 8'h00);
    end
    drive_column(COL_IDLE, 8'hff);
    repeat (2) @(posedge mgt_clk);
    bus_read(REG_STATUS, st);
    check_value("rx_empty after stray data", 64'd1, 64'(st[3]));
    // a full frame while the link is down.
    @(posedge mgt_clk);
    mgt_syncok_i <= 4'b0111;
    wait_link(1'b0);
    drive_frame(rand_word(), rand_word());
    bus_read(REG_STATUS, st);
    check_value("rx_empty after frame with link down", 64'd1, 64'(st[3]));
    @(posedge mgt_clk);
    mgt_syncok_i <= 4'hf;
    wait_link(1'b1);
    w0 = rand_word();
    w1 = rand_word();
    drive_frame(w0, w1);
    check_rx_word(w0);
    check_rx_word(w1);
    bus_read(REG_STATUS, st);
    check_value("rx_empty after valid frame", 64'd1, 64'(st[3]));
    // txen low holds the words back.
    bus_write(REG_CTRL, 16'h0000);
    frame_base = mon_bursts.size();
    data_base  = mon_data_total;
    write_tx_word(rand_word());
    write_tx_word(rand_word());
    repeat (40) @(posedge mgt_clk);
    check_value("frames with txen low", 64'd0, 64'(mon_bursts.size() - frame_base));
    bus_read(REG_STATUS, st);
    check_value("tx_empty with txen low", 64'd0, 64'(st[1]));
    bus_write(REG_CTRL, 16'h0001);
    wait_tx_drain(data_base + 2);
    bus_read(REG_STATUS, st);
    check_value("tx_empty after txen set", 64'd1, 64'(st[1]));
    close_test();
  endtask

  task automatic overflow_soft_reset();
    logic [15:0] st;
    logic [15:0] mask;
    open_test("overflow_soft_reset");
    bus_write(REG_CTRL, 16'h0000);
    for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
      write_tx_word(rand_word());
    end
    mask = status_word(0, 1, 1, 0, 0, 1, 0);
    bus_read(REG_STATUS, st);
    check_value("tx flags when full", 64'(status_word(0, 0, 1, 0, 0, 1, 0)), 64'(st & mask));
    bus_write(REG_CTRL, 16'h000c);
    // link bit masked since lane sync restarts after the soft reset.
    bus_read(REG_STATUS, st);
    check_value("status after soft reset", 64'(status_word(0, 1, 0, 1, 0, 0, 0)),
                64'(st & 16'hfffe));
    bus_read(REG_CTRL, st);
    check_value("ctrl after soft reset", 64'h4, 64'(st));
    @(negedge mgt_clk);
    check_value("powerdown pin", 64'd1, 64'(mgt_powerdown_o));
    close_test();
  endtask

  // ##############################
  // main sequence
  // ##############################

  initial begin
    reset        <= 1'b1;
    reg_stb_i    <= 1'b0;
    reg_we_i     <= 1'b0;
    reg_adr_i    <= REG_CTRL;
    reg_dat_i    <= 16'd0;
    mgt_syncok_i <= 4'h0;
    loop_en      <= 1'b0;
    rx_drv_data  <= COL_IDLE;
    rx_drv_k     <= 8'hff;
    repeat (2) @(posedge mgt_clk);
    reset <= 1'b0;
    reset_defaults();
    qualify_link();
    loopback_transfer();
    framing_rules();
    receive_filtering();
    overflow_soft_reset();
    $display("%0d tests run, %0d failing, %0d errors", n_tests, n_failed,
             err_count + mon_err);
    if (n_failed == 0 && err_count + mon_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // cycle limit well above the length of all tests.
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge mgt_clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles while in %s", cycle_cnt, cur_test);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/xaui_pkg.sv
source/xaui_fifo.sv
source/xaui_lane_sync.sv
source/xaui_transfer_engine.sv
source/xaui_pipe_ctrl.sv
source/xaui_pipe.sv
verif/xaui_pipe_tb.sv

/* Makefile */
SRCS := $(wildcard source/*.sv)

.PHONY: run clean

run: obj_dir/Vxaui_pipe_tb
	@out=$$(./obj_dir/Vxaui_pipe_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed"

# rebuilt only when the testbench, an RTL source or the file list changes.
obj_dir/V%: verif/%.sv $(SRCS) sim.f
	verilator --binary --timing --assert -f sim.f --top-module $* -Mdir obj_dir

clean:
	rm -rf obj_dir
